// File: design/dphy_pkg.sv
package dphy_pkg;

  ////////////////////////////////////////////////////////////
  // lane setup
  ////////////////////////////////////////////////////////////

  // must divide WORD_BYTES.
  localparam int DATA_LANES = 2;

  // bytes in one mapped output word.
  localparam int WORD_BYTES = 4;

  // high-speed sync pattern, sent LSB first.
  localparam logic [7:0] SYNC_BYTE = 8'hB8;

  ////////////////////////////////////////////////////////////
  // deskew
  ////////////////////////////////////////////////////////////

  // entries per lane fifo.
  localparam int SKEW_DEPTH = 4;
  localparam int SKEW_AW    = $clog2(SKEW_DEPTH);

  ////////////////////////////////////////////////////////////
  // shared types
  ////////////////////////////////////////////////////////////

  // lane 0 sits in the low byte.
  typedef logic [DATA_LANES-1:0][7:0] lane_bytes_t;

  // one aligned byte of one lane.
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } lane_byte_t;

  // one skew-free beat of all lanes.
  typedef struct packed {
    logic        valid;
    lane_bytes_t data;
  } lane_word_t;

  // mapper output.
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } rx_word_t;

endpackage

// File: design/dphy_byte_align.sv
`timescale 1ns/1ns

module dphy_byte_align (
  input  logic                 byte_clk_i,
  input  logic                 rst_i,
  input  logic                 enable_i,
  input  logic                 reset_align_i,
  input  logic [7:0]           unaligned_byte_i,
  output dphy_pkg::lane_byte_t aligned_o
);

  import dphy_pkg::*;

  logic [7:0]  prev_byte;
  logic [15:0] window;
  logic        locked;
  logic [2:0]  offset;
  logic        sync_hit;
  logic [2:0]  sync_pos;
  logic        out_valid;
  logic [7:0]  out_data;

  ////////////////////////////////////////////////////////////
  // bit window
  ////////////////////////////////////////////////////////////

  // earliest bit is window[0].
  assign window = {unaligned_byte_i, prev_byte};

  always_ff @(posedge byte_clk_i)
  begin
    prev_byte <= unaligned_byte_i;
  end

  ////////////////////////////////////////////////////////////
  // sync search
  ////////////////////////////////////////////////////////////

  // Scan from the top down so the lowest matching offset is the one
  // left in sync_pos.
  always_comb
  begin
    sync_hit = 1'b0;
    sync_pos = '0;
    for (int i = 7; i >= 0; i--)
    begin
      if (window[i +: 8] == SYNC_BYTE)
      begin
        sync_hit = 1'b1;
        sync_pos = 3'(i);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // lock and output
  ////////////////////////////////////////////////////////////

  always_ff @(posedge byte_clk_i)
  begin
    if (rst_i)
    begin
      locked    <= 1'b0;
      offset    <= '0;
      out_valid <= 1'b0;
    end
    else if (reset_align_i || !enable_i)
    begin
      locked    <= 1'b0;            // drop lock, search again.
      out_valid <= 1'b0;
    end
    else if (locked)
    begin
      out_valid <= 1'b1;
    end
    else if (sync_hit)
    begin
      locked <= 1'b1;               // sync byte itself is not output.
      offset <= sync_pos;
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    out_data <= window[offset +: 8];
  end

  assign aligned_o.valid = out_valid;
  assign aligned_o.data  = out_data;

endmodule

// File: design/dphy_word_align.sv
`timescale 1ns/1ns

module dphy_word_align (
  input  logic                                            byte_clk_i,
  input  logic                                            rst_i,
  input  logic                                            enable_i,
  input  logic                                            eop_i,
  input  dphy_pkg::lane_byte_t [dphy_pkg::DATA_LANES-1:0] lanes_i,
  output logic                                            reset_align_o,
  output dphy_pkg::lane_word_t                            word_o
);

  import dphy_pkg::*;

  logic [7:0]                         fifo_mem [DATA_LANES][SKEW_DEPTH];
  logic [DATA_LANES-1:0][SKEW_AW-1:0] wr_ptr;
  logic [DATA_LANES-1:0][SKEW_AW-1:0] rd_ptr;
  logic [DATA_LANES-1:0][SKEW_AW:0]   fill;
  logic [DATA_LANES-1:0]              lane_valid;
  logic [DATA_LANES-1:0]              push;
  logic [DATA_LANES-1:0]              full;
  logic [DATA_LANES-1:0]              not_empty;
  logic                               enable_d;
  logic                               enable_fall;
  logic                               pop;
  logic                               overflow;
  logic                               flush;
  logic                               drop_pkt;
  logic                               drain;
  logic                               word_valid;
  lane_bytes_t                        word_data;

  always_comb
  begin
    for (int i = 0; i < DATA_LANES; i++)
    begin
      lane_valid[i] = lanes_i[i].valid;
      not_empty[i]  = (fill[i] != '0);
      full[i]       = (fill[i] == (SKEW_AW+1)'(SKEW_DEPTH));
      push[i]       = lanes_i[i].valid && !drop_pkt && !drain;
    end
  end

  assign enable_fall = enable_d && !enable_i;
  assign pop         = (&not_empty) && !eop_i && !enable_fall;
  assign overflow    = |(push & full) && !pop;   // a pop makes room.
  assign flush       = eop_i || enable_fall || overflow;

  ////////////////////////////////////////////////////////////
  // packet state
  ////////////////////////////////////////////////////////////

  // drop_pkt holds off an overflowed packet until it ends, since the
  // realigned lanes may lock on a stray sync match in the payload.
  // drain ignores bytes still in flight until every lane has unlocked.
  always_ff @(posedge byte_clk_i)
  begin
    if (rst_i)
    begin
      enable_d      <= 1'b0;
      reset_align_o <= 1'b0;
      drop_pkt      <= 1'b0;
      drain         <= 1'b0;
    end
    else
    begin
      enable_d      <= enable_i;
      reset_align_o <= flush;
      if (eop_i || enable_fall)
        drop_pkt <= 1'b0;
      else if (overflow)
        drop_pkt <= 1'b1;
      if (flush)
        drain <= 1'b1;
      else if (!(|lane_valid))
        drain <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // skew fifos
  ////////////////////////////////////////////////////////////

  always_ff @(posedge byte_clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill       <= '0;
      word_valid <= 1'b0;
    end
    else
    begin
      word_valid <= pop;
      for (int i = 0; i < DATA_LANES; i++)
      begin
        if (flush)
        begin
          wr_ptr[i] <= '0;
          rd_ptr[i] <= '0;
          fill[i]   <= '0;
        end
        else
        begin
          if (push[i])
            wr_ptr[i] <= wr_ptr[i] + 1'b1;
          if (pop)
            rd_ptr[i] <= rd_ptr[i] + 1'b1;
          fill[i] <= fill[i] + (SKEW_AW+1)'(push[i]) - (SKEW_AW+1)'(pop);
        end
      end
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    for (int i = 0; i < DATA_LANES; i++)
    begin
      if (push[i])
        fifo_mem[i][wr_ptr[i]] <= lanes_i[i].data;
      if (pop)
        word_data[i] <= fifo_mem[i][rd_ptr[i]];  // one entry per lane.
    end
  end

  assign word_o.valid = word_valid;
  assign word_o.data  = word_data;

endmodule

// File: design/dphy_32b_map.sv
`timescale 1ns/1ns

module dphy_32b_map (
  input  logic                 byte_clk_i,
  input  logic                 rst_i,
  input  logic                 eop_i,
  input  dphy_pkg::lane_word_t word_i,
  output dphy_pkg::rx_word_t   rx_o
);

  import dphy_pkg::*;

  logic [1:0]                  byte_pos;
  logic [WORD_BYTES-1:0][7:0]  acc;
  logic [WORD_BYTES-1:0][7:0]  word_next;
  logic                        last_beat;
  logic                        held;
  logic                        emit;
  logic                        out_valid;
  logic [31:0]                 out_data;

  ////////////////////////////////////////////////////////////
  // byte packing
  ////////////////////////////////////////////////////////////

  // lane 0 lands at the current byte position.
  always_comb
  begin
    word_next = acc;
    if (word_i.valid)
    begin
      for (int l = 0; l < DATA_LANES; l++)
        word_next[int'(byte_pos) + l] = word_i.data[l];
    end
  end

  assign last_beat = word_i.valid && (int'(byte_pos) + DATA_LANES == WORD_BYTES);
  assign held      = word_i.valid || (byte_pos != '0);   // beat on the eop cycle counts.
  assign emit      = last_beat || (eop_i && held);

  ////////////////////////////////////////////////////////////
  // accumulator
  ////////////////////////////////////////////////////////////

  // acc is cleared after every word so a partial word at end of
  // packet goes out with its missing bytes already zero.
  always_ff @(posedge byte_clk_i)
  begin
    if (rst_i)
    begin
      byte_pos  <= '0;
      acc       <= '0;
      out_valid <= 1'b0;
    end
    else
    begin
      out_valid <= emit;
      if (emit)
      begin
        byte_pos <= '0;
        acc      <= '0;
      end
      else if (word_i.valid)
      begin
        byte_pos <= byte_pos + 2'(DATA_LANES);
        acc      <= word_next;
      end
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (emit)
      out_data <= word_next;
  end

  assign rx_o.valid = out_valid;
  assign rx_o.data  = out_data;

endmodule

// File: design/dphy_rx_core.sv
`timescale 1ns/1ns

module dphy_rx_core (
  input  logic                  byte_clk_i,
  input  logic                  rst_i,
  input  logic                  enable_i,
  input  logic                  eop_i,
  input  dphy_pkg::lane_bytes_t raw_bytes_i,
  output logic [31:0]           data_o,
  output logic                  valid_o
);

  import dphy_pkg::*;

  lane_byte_t [DATA_LANES-1:0] aligned_bytes;
  logic                        reset_align;
  lane_word_t                  lane_word;
  rx_word_t                    rx_word;

  ////////////////////////////////////////////////////////////
  // per-lane bit alignment
  ////////////////////////////////////////////////////////////

  generate
    for (genvar i = 0; i < DATA_LANES; i++)
    begin : byte_align
      dphy_byte_align lane_align (
        .byte_clk_i       ( byte_clk_i       ),
        .rst_i            ( rst_i            ),
        .enable_i         ( enable_i         ),
        .reset_align_i    ( reset_align      ),
        .unaligned_byte_i ( raw_bytes_i[i]   ),
        .aligned_o        ( aligned_bytes[i] )
      );
    end
  endgenerate

  ////////////////////////////////////////////////////////////
  // deskew and word mapping
  ////////////////////////////////////////////////////////////

  dphy_word_align word_align (
    .byte_clk_i    ( byte_clk_i    ),
    .rst_i         ( rst_i         ),
    .enable_i      ( enable_i      ),
    .eop_i         ( eop_i         ),
    .lanes_i       ( aligned_bytes ),
    .reset_align_o ( reset_align   ),
    .word_o        ( lane_word     )
  );

  dphy_32b_map mapper (
    .byte_clk_i ( byte_clk_i ),
    .rst_i      ( rst_i      ),
    .eop_i      ( eop_i      ),
    .word_i     ( lane_word  ),
    .rx_o       ( rx_word    )
  );

  assign data_o  = rx_word.data;
  assign valid_o = rx_word.valid;

endmodule

// File: tb/dphy_rx_vectors.svh
`ifndef DPHY_RX_VECTORS_SVH
`define DPHY_RX_VECTORS_SVH

// one test packet; per-lane fields are indexed by lane.
typedef struct packed {
  logic [DATA_LANES-1:0][2:0] offset;     // bit offset ahead of the sync byte.
  logic [DATA_LANES-1:0][2:0] skew;       // whole bytes of lane delay.
  logic [7:0]                 len;        // payload bytes.
  logic                       enable;     // enable_i level for the packet.
  logic                       words_due;  // words expected at all.
} vector_t;

localparam int NUM_ROWS = 12;

// columns: offset {lane 1, lane 0}, skew {lane 1, lane 0}, length, enable, words due
localparam vector_t VECTORS [NUM_ROWS] = '{
  '{{3'd0, 3'd0}, {3'd0, 3'd0}, 8'd16, 1'b1, 1'b1},   // plain packet.
  '{{3'd5, 3'd3}, {3'd0, 3'd0}, 8'd20, 1'b1, 1'b1},   // bit offsets.
  '{{3'd2, 3'd7}, {3'd0, 3'd1}, 8'd24, 1'b1, 1'b1},
  '{{3'd1, 3'd6}, {3'd3, 3'd0}, 8'd16, 1'b1, 1'b1},   // widest legal skew.
  '{{3'd4, 3'd0}, {3'd2, 3'd0}, 8'd12, 1'b1, 1'b1},
  '{{3'd0, 3'd0}, {3'd0, 3'd0}, 8'd14, 1'b1, 1'b1},   // two bytes short.
  '{{3'd6, 3'd2}, {3'd1, 3'd0}, 8'd13, 1'b1, 1'b1},   // three bytes short.
  '{{3'd3, 3'd5}, {3'd0, 3'd2}, 8'd11, 1'b1, 1'b1},   // one byte short.
  '{{3'd0, 3'd1}, {3'd5, 3'd0}, 8'd16, 1'b1, 1'b0},   // fifo overflow.
  '{{3'd7, 3'd4}, {3'd0, 3'd1}, 8'd16, 1'b1, 1'b1},   // recovery.
  '{{3'd0, 3'd0}, {3'd0, 3'd0}, 8'd16, 1'b0, 1'b0},   // lanes disabled.
  '{{3'd2, 3'd3}, {3'd1, 3'd0}, 8'd8,  1'b1, 1'b1}
};

`endif

// File: tb/tb_dphy_rx.sv
`timescale 1ns/1ns

module tb_dphy_rx;

  import dphy_pkg::*;

  `include "dphy_rx_vectors.svh"

  localparam int RESET_CYCLES   = 8;
  localparam int DRAIN_CYCLES   = 8;
  localparam int ROW_OVERHEAD   = 8;
  localparam int TIMEOUT_MARGIN = 50;
  localparam int MAX_LEN        = 256;
  localparam int MAX_STREAM     = 64;    // raw bytes per lane and row.
  localparam int EXP_SLOTS      = 256;

  logic        byte_clk = 1'b0;
  logic        rst;
  logic        enable;
  logic        eop;
  lane_bytes_t raw_bytes;
  logic [31:0] rx_data;
  logic        rx_valid;

  logic [31:0]               lfsr_state = 32'hbcd5eadb;
  logic [7:0]                payload [MAX_LEN];
  logic [8*MAX_STREAM-1:0]   lane_bits [DATA_LANES];
  logic [31:0]               exp_words [EXP_SLOTS];
  int                        exp_wr         = 0;
  int                        exp_base       = 0;
  int                        exp_rd         = 0;
  int                        words_seen     = 0;
  int                        check_count    = 0;
  int                        mismatch_count = 0;
  int                        extra_count    = 0;
  int                        fault_count    = 0;
  int                        cycle_count    = 0;
  int                        timeout_limit  = 0;

  dphy_rx_core dut0 (
    .byte_clk_i  ( byte_clk  ),
    .rst_i       ( rst       ),
    .enable_i    ( enable    ),
    .eop_i       ( eop       ),
    .raw_bytes_i ( raw_bytes ),
    .data_o      ( rx_data   ),
    .valid_o     ( rx_valid  )
  );

  always #50 byte_clk = ~byte_clk;

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [7:0] random_byte();
    logic [7:0] b;
    for (int i = 0; i < 8; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      b[i]       = lfsr_state[0];
    end
    return b;
  endfunction

  function automatic int max_skew(input vector_t v);
    int m;
    m = 0;
    for (int l = 0; l < DATA_LANES; l++)
    begin
      if (int'(v.skew[l]) > m)
        m = int'(v.skew[l]);
    end
    return m;
  endfunction

  function automatic int cycle_budget();
    int total;
    total = RESET_CYCLES + TIMEOUT_MARGIN;
    for (int r = 0; r < NUM_ROWS; r++)
      total += int'(VECTORS[r].len) + max_skew(VECTORS[r]) + ROW_OVERHEAD + DRAIN_CYCLES;
    return total;
  endfunction

  function automatic int total_errors();
    return mismatch_count + extra_count + fault_count;
  endfunction

  // zeros for skew and offset, sync, round-robin payload, zero tail.
  task automatic build_stream(input vector_t v, input int len);
    int pos;
    for (int l = 0; l < DATA_LANES; l++)
    begin
      lane_bits[l] = '0;
      pos = 8 * int'(v.skew[l]) + int'(v.offset[l]);
      for (int b = 0; b < 8; b++)
        lane_bits[l][pos + b] = SYNC_BYTE[b];
      pos += 8;
      for (int k = l; k < len; k += DATA_LANES)
      begin
        for (int b = 0; b < 8; b++)
          lane_bits[l][pos + b] = payload[k][b];
        pos += 8;
      end
    end
  endtask

  // byte n of the packet lands in byte n mod 4 of word n / 4.
  task automatic queue_expected(input int len);
    logic [31:0] word;
    for (int w = 0; w < (len + WORD_BYTES - 1) / WORD_BYTES; w++)
    begin
      word = '0;
      for (int b = 0; b < WORD_BYTES; b++)
      begin
        if (WORD_BYTES * w + b < len)
          word[8*b +: 8] = payload[WORD_BYTES * w + b];
      end
      exp_words[exp_wr] = word;
      exp_wr++;
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    check_count++;
    if (actual !== expected)
    begin
      $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
      mismatch_count++;
    end
  endtask

  task automatic apply_row(input int idx);
    vector_t v;
    int      len;
    int      beats;
    int      eop_idx;
    int      errs_before;
    int      seen_before;
    int      consumed;
    int      missing;
    v           = VECTORS[idx];
    len         = int'(v.len);
    beats       = (len + DATA_LANES - 1) / DATA_LANES;
    // lock at skew+1, byte out at +2, push at +3, pop at +4.
    eop_idx     = max_skew(v) + 4 + beats;
    errs_before = total_errors();
    seen_before = words_seen;
    for (int k = 0; k < len; k++)
      payload[k] = random_byte();
    exp_base = exp_wr;
    if (v.words_due)
      queue_expected(len);
    build_stream(v, len);
    for (int k = 0; k <= eop_idx; k++)
    begin
      @(posedge byte_clk);
      enable <= v.enable;
      eop    <= (k == eop_idx);        // lands on the last beat.
      for (int l = 0; l < DATA_LANES; l++)
        raw_bytes[l] <= lane_bits[l][8*k +: 8];
    end
    @(posedge byte_clk);
    enable    <= 1'b0;
    eop       <= 1'b0;
    raw_bytes <= '0;
    repeat (DRAIN_CYCLES - 1) @(posedge byte_clk);
    consumed = (exp_rd > exp_base) ? exp_rd : exp_base;
    missing  = exp_wr - consumed;
    if (missing > 0)
    begin
      $display("ERROR: row %0d ended with %0d expected words never received", idx, missing);
      fault_count++;
    end
    $display("row %0d: %0d words received, %0d errors", idx, words_seen - seen_before,
             total_errors() - errs_before);
  endtask

  ////////////////////////////////////////////////////////////
  // output checking
  ////////////////////////////////////////////////////////////

  always @(negedge byte_clk)
  begin
    if (!rst && rx_valid)
    begin
      words_seen++;
      if (exp_rd < exp_base)
        exp_rd = exp_base;             // skip words lost in an earlier row.
      if (exp_rd < exp_wr)
      begin
        compare_value("data_o", rx_data, exp_words[exp_rd]);
        exp_rd++;
      end
      else
      begin
        $display("ERROR: valid_o pulsed with no word expected, data_o %h", rx_data);
        extra_count++;
      end
    end
  end

  always @(posedge byte_clk)
  begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit)
    begin
      $display("ERROR: run did not finish within %0d cycles", timeout_limit);
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    rst           = 1'b1;
    enable        = 1'b0;
    eop           = 1'b0;
    raw_bytes     = '0;
    timeout_limit = cycle_budget();
    repeat (RESET_CYCLES) @(posedge byte_clk);
    rst <= 1'b0;
    for (int r = 0; r < NUM_ROWS; r++)
      apply_row(r);
    $display("%0d rows, %0d checks, %0d errors", NUM_ROWS, check_count, total_errors());
    if (total_errors() == 0)
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+tb
design/dphy_pkg.sv
design/dphy_byte_align.sv
design/dphy_word_align.sv
design/dphy_32b_map.sv
design/dphy_rx_core.sv
tb/tb_dphy_rx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it, and judge the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing -sv --top-module tb_dphy_rx -f project.f \
  -Mdir obj_dir -o tb_dphy_rx_sim > build.log 2>&1 \
  && ./obj_dir/tb_dphy_rx_sim > sim.log 2>&1 \
  || { cat build.log; echo "build or simulation error"; }

[ -f sim.log ] && cat sim.log
grep -qx "Regression passed" sim.log 2>/dev/null && exit 0 || exit 1
